//--- logic/armCtrl_cfg.svh
`ifndef ARM_CTRL_CFG_SVH
`define ARM_CTRL_CFG_SVH

// ==============================
// Instruction fetch side
// ==============================

// One ARM instruction word per cycle
`define ARM_INSTR_WIDTH 32

// ==============================
// Pipeline shape
// ==============================

// Stages after decode (execute, memory, writeback)
`define ARM_NUM_STAGES 3

// NZCV register
`define ARM_FLAG_WIDTH 4

`endif

//--- logic/armIsaPkg.sv
package armIsaPkg;

  // ==============================
  // Condition field, bits 31:28
  // ==============================
  typedef enum logic [3:0] {
    condEq = 4'b0000,  // Z set
    condNe = 4'b0001,  // Z clear
    condCs = 4'b0010,  // C set
    condCc = 4'b0011,  // C clear
    condMi = 4'b0100,  // N set
    condPl = 4'b0101,  // N clear
    condVs = 4'b0110,  // V set
    condVc = 4'b0111,  // V clear
    condHi = 4'b1000,  // Unsigned higher
    condLs = 4'b1001,  // Unsigned lower or same
    condGe = 4'b1010,  // Signed >=
    condLt = 4'b1011,  // Signed <
    condGt = 4'b1100,  // Signed >
    condLe = 4'b1101,  // Signed <=
    condAl = 4'b1110,  // Always
    condNv = 4'b1111   // Never
  } condCode_t;

  // Decoder classification
  typedef enum logic [2:0] {
    dataImm        = 3'd0,
    dataReg        = 3'd1,
    loadStore      = 3'd2,
    branch         = 3'd3,
    branchExchange = 3'd4,
    undefined      = 3'd7
  } instrClass_t;

  // Data processing opcode, bits 24:21
  typedef enum logic [3:0] {
    aluAnd, aluEor, aluSub, aluRsb,
    aluAdd, aluAdc, aluSbc, aluRsc,
    aluTst, aluTeq, aluCmp, aluCmn,  // Flags only, no result
    aluOrr, aluMov, aluBic, aluMvn
  } aluOp_t;

  // Bit positions inside NZCV
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

endpackage

//--- logic/armCtrlPkg.sv
package armCtrlPkg;

  // ==============================
  // Decoded control word
  // ==============================

  // Carried unchanged from decode to commit
  typedef struct packed {
    armIsaPkg::condCode_t cond;        // Checked at commit
    armIsaPkg::aluOp_t    aluControl;  // Opcode for the ALU
    logic                 aluSrc;      // Immediate operand B
    logic                 regWrite;    // Writes rd
    logic                 memWrite;    // STR
    logic                 memToReg;    // LDR result from memory
    logic                 byteAccess;  // LDRB / STRB
    logic                 branch;      // B or BX
    logic                 pcSrc;       // New PC from this instruction
    logic                 flagWrite;   // S bit
    logic [3:0]           rd;          // Destination register
    logic                 undef;       // Unsupported encoding
  } ctrlWord_t;

  // ==============================
  // Stage payload
  // ==============================

  // Every stage register carries the full control word
  typedef ctrlWord_t stagePayload_t;

endpackage

//--- logic/instrDecoder.sv
`timescale 1ns/1ns
`include "armCtrl_cfg.svh"

module instrDecoder (
  input  logic [`ARM_INSTR_WIDTH-1:0] instr,
  input  logic                        instrValid,
  output armCtrlPkg::ctrlWord_t       ctrl,
  output logic                        ctrlValid
);

  armIsaPkg::instrClass_t instrClass;
  logic [5:0]             controls;
  logic                   aluSrc, regWrite, memWrite, memToReg, branch, aluOp;
  logic                   isLoadStore, isBranch;
  logic [3:0]             rd;

  // ==============================
  // Classification
  // ==============================
  always_comb begin
    case (instr[27:26])
      2'b00: begin
        if (instr[25])
          instrClass = armIsaPkg::dataImm;
        else if (instr[27:4] == 24'h12_FFF1)  // BX Rm
          instrClass = armIsaPkg::branchExchange;
        else if (instr[7] & instr[4])  // Multiply and halfword space
          instrClass = armIsaPkg::undefined;
        else if (instr[24:23] == 2'b10 & ~instr[20])  // MRS/MSR space
          instrClass = armIsaPkg::undefined;
        else
          instrClass = armIsaPkg::dataReg;
      end
      2'b01: begin
        // Register offset with bit 4 set is the media space
        if (instr[25] & instr[4]) instrClass = armIsaPkg::undefined;
        else                      instrClass = armIsaPkg::loadStore;
      end
      2'b10: begin
        // B only, no link and no LDM/STM
        if (instr[25] & ~instr[24]) instrClass = armIsaPkg::branch;
        else                        instrClass = armIsaPkg::undefined;
      end
      default: instrClass = armIsaPkg::undefined;  // Coprocessor and SWI
    endcase
  end

  // ==============================
  // Control table
  // ==============================

  // {aluSrc, regWrite, memWrite, memToReg, branch, aluOp}
  always_comb begin
    case (instrClass)
      armIsaPkg::dataImm:        controls = 6'b110001;  // Imm operand
      armIsaPkg::dataReg:        controls = 6'b010001;  // Reg operand
      armIsaPkg::loadStore: begin
        if (instr[20]) controls = {~instr[25], 5'b10100};  // LDR
        else           controls = {~instr[25], 5'b01000};  // STR
      end
      armIsaPkg::branch:         controls = 6'b100010;  // Imm24 offset
      armIsaPkg::branchExchange: controls = 6'b000010;  // Target in Rm
      default:                   controls = 6'b000000;  // No writes
    endcase
  end

  assign {aluSrc, regWrite, memWrite, memToReg, branch, aluOp} = controls;

  assign isLoadStore = (instrClass == armIsaPkg::loadStore);
  assign isBranch    = branch;

  // Branches target the PC
  assign rd = isBranch ? 4'd15 : instr[15:12];

  always_comb begin
    ctrl            = '0;
    ctrl.cond       = armIsaPkg::condCode_t'(instr[31:28]);
    ctrl.aluSrc     = aluSrc;
    ctrl.regWrite   = regWrite;
    ctrl.memWrite   = memWrite;
    ctrl.memToReg   = memToReg;
    ctrl.branch     = branch;
    ctrl.rd         = rd;
    ctrl.undef      = (instrClass == armIsaPkg::undefined);

    if (aluOp) begin  // Data processing
      ctrl.aluControl = armIsaPkg::aluOp_t'(instr[24:21]);
      ctrl.flagWrite  = instr[20];  // S bit
    end else if (isLoadStore) begin
      // U bit picks offset direction
      ctrl.aluControl = instr[23] ? armIsaPkg::aluAdd : armIsaPkg::aluSub;
      ctrl.flagWrite  = 1'b0;
    end else begin
      ctrl.aluControl = armIsaPkg::aluAdd;  // Branch target add
      ctrl.flagWrite  = 1'b0;
    end

    ctrl.byteAccess = isLoadStore & instr[22];  // B bit
    ctrl.pcSrc      = (regWrite & (rd == 4'd15)) | branch;  // Write to r15 or branch
  end

  assign ctrlValid = instrValid;

endmodule

//--- logic/pipeStage.sv
`timescale 1ns/1ns

module pipeStage #(
  parameter type payloadType = armCtrlPkg::stagePayload_t
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,
  input  logic       flush,
  input  payloadType payloadIn,
  input  logic       validIn,
  output payloadType payloadOut,
  output logic       validOut,
  output logic       pending
);

  // ==============================
  // Valid bit
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      validOut <= 1'b0;
    end else if (!stall) begin
      validOut <= validIn & ~flush;  // Flush loads a bubble
    end
  end

  // Payload follows the valid bit enable
  always_ff @(posedge clk) begin
    if (!stall) begin
      payloadOut <= payloadIn;
    end
  end

  // Live instruction here will redirect the PC
  assign pending = validOut & payloadOut.pcSrc;

endmodule

//--- logic/condCommit.sv
`timescale 1ns/1ns
`include "armCtrl_cfg.svh"

module condCommit (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       stall,
  input  armCtrlPkg::ctrlWord_t      ctrl,
  input  logic                       ctrlValid,
  input  logic [`ARM_FLAG_WIDTH-1:0] aluFlags,
  output logic                       regWrite,
  output logic                       memWrite,
  output logic                       memToReg,
  output logic                       byteAccess,
  output logic                       pcWrite,
  output logic [3:0]                 rd,
  output logic                       undefInstr,
  output logic                       commitValid,
  output logic [`ARM_FLAG_WIDTH-1:0] flags
);

  logic n, z, c, v;
  logic condPass;
  logic commitEn;
  logic testOp;

  assign n = flags[armIsaPkg::flagN];
  assign z = flags[armIsaPkg::flagZ];
  assign c = flags[armIsaPkg::flagC];
  assign v = flags[armIsaPkg::flagV];

  // ==============================
  // Condition check
  // ==============================
  always_comb begin
    case (ctrl.cond)
      armIsaPkg::condEq: condPass = z;
      armIsaPkg::condNe: condPass = ~z;
      armIsaPkg::condCs: condPass = c;
      armIsaPkg::condCc: condPass = ~c;
      armIsaPkg::condMi: condPass = n;
      armIsaPkg::condPl: condPass = ~n;
      armIsaPkg::condVs: condPass = v;
      armIsaPkg::condVc: condPass = ~v;
      armIsaPkg::condHi: condPass = c & ~z;
      armIsaPkg::condLs: condPass = ~c | z;
      armIsaPkg::condGe: condPass = (n == v);
      armIsaPkg::condLt: condPass = (n != v);
      armIsaPkg::condGt: condPass = ~z & (n == v);
      armIsaPkg::condLe: condPass = z | (n != v);
      armIsaPkg::condAl: condPass = 1'b1;
      default:           condPass = 1'b0;  // NV never executes
    endcase
  end

  assign commitEn = ctrlValid & condPass;

  // TST/TEQ/CMP/CMN only touch the flags
  assign testOp = ctrl.aluControl inside {armIsaPkg::aluTst, armIsaPkg::aluTeq,
                                          armIsaPkg::aluCmp, armIsaPkg::aluCmn};

  // ==============================
  // Gated commit outputs
  // ==============================
  assign regWrite    = commitEn & ctrl.regWrite & ~testOp;
  assign memWrite    = commitEn & ctrl.memWrite;
  assign pcWrite     = commitEn & ctrl.pcSrc & ~testOp;  // pcSrc covers B and BX
  assign undefInstr  = commitEn & ctrl.undef;
  assign memToReg    = ctrl.memToReg;    // Meaningful with commitValid
  assign byteAccess  = ctrl.byteAccess;
  assign rd          = ctrl.rd;
  assign commitValid = ctrlValid;

  // NZCV register, updated in program order
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (commitEn & ctrl.flagWrite & ~stall) begin
      flags <= aluFlags;  // Datapath flags for this instruction
    end
  end

endmodule

//--- logic/armControlTop.sv
`timescale 1ns/1ns
`include "armCtrl_cfg.svh"

module armControlTop (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`ARM_INSTR_WIDTH-1:0] instr,
  input  logic                        instrValid,
  input  logic                        stall,
  input  logic                        flush,
  input  logic [`ARM_FLAG_WIDTH-1:0]  aluFlags,
  output logic                        regWrite,
  output logic                        memWrite,
  output logic                        memToReg,
  output logic                        byteAccess,
  output logic                        pcWrite,
  output logic [3:0]                  rd,
  output logic                        undefInstr,
  output logic                        commitValid,
  output logic [`ARM_FLAG_WIDTH-1:0]  flags,
  output logic                        pcWritePending
);

  // Index 0 is the decoder output, last index feeds commit
  armCtrlPkg::stagePayload_t stagePayload [`ARM_NUM_STAGES+1];
  logic [`ARM_NUM_STAGES:0]   stageValid;
  logic [`ARM_NUM_STAGES-1:0] stagePending;

  // ==============================
  // Decode
  // ==============================
  instrDecoder decoder0 (
    .instr     (instr),
    .instrValid(instrValid),
    .ctrl      (stagePayload[0]),
    .ctrlValid (stageValid[0])
  );

  // ==============================
  // Stage chain
  // ==============================
  for (genvar i = 0; i < `ARM_NUM_STAGES; i++) begin : gStage
    pipeStage #(
      .payloadType(armCtrlPkg::stagePayload_t)
    ) stage (
      .clk       (clk),
      .reset     (reset),
      .stall     (stall),         // Holds the whole chain
      .flush     (flush),         // Bubbles every stage
      .payloadIn (stagePayload[i]),
      .validIn   (stageValid[i]),
      .payloadOut(stagePayload[i+1]),
      .validOut  (stageValid[i+1]),
      .pending   (stagePending[i])
    );
  end

  // Any in-flight PC write
  assign pcWritePending = |stagePending;

  condCommit commit0 (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .ctrl       (stagePayload[`ARM_NUM_STAGES]),
    .ctrlValid  (stageValid[`ARM_NUM_STAGES]),
    .aluFlags   (aluFlags),
    .regWrite   (regWrite),
    .memWrite   (memWrite),
    .memToReg   (memToReg),
    .byteAccess (byteAccess),
    .pcWrite    (pcWrite),
    .rd         (rd),
    .undefInstr (undefInstr),
    .commitValid(commitValid),
    .flags      (flags)
  );

endmodule

//--- verif/armControlVectors.svh
`ifndef ARM_CONTROL_VECTORS_SVH
`define ARM_CONTROL_VECTORS_SVH

// Columns: test, instr, instrValid, stall, flush, flagsDontCare, aluFlags,
//   expect {regWrite, memWrite, memToReg, byteAccess, pcWrite, flagWrite, undef}, rd
// Write columns hold the commit values for a passed condition
task automatic loadVectors();
  // ==============================
  // 1 Decode, all AL
  // ==============================
  addRow(1, 32'hE0821003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd1);   // ADD r1, r2, r3
  addRow(1, 32'hE2554001, 1, 0, 0, 1, 4'h0, 7'b1000010, 4'd4);   // SUBS r4, r5, #1
  addRow(1, 32'hE3A0F008, 1, 0, 0, 1, 4'h0, 7'b1000100, 4'd15);  // MOV pc, #8
  addRow(1, 32'hE5976004, 1, 0, 0, 1, 4'h0, 7'b1010000, 4'd6);   // LDR r6, [r7, #4]
  addRow(1, 32'hE5498002, 1, 0, 0, 1, 4'h0, 7'b0101000, 4'd8);   // STRB r8, [r9, #-2]
  addRow(1, 32'hEA000010, 1, 0, 0, 1, 4'h0, 7'b0000100, 4'd15);  // B
  addRow(1, 32'hE12FFF1E, 1, 0, 0, 1, 4'h0, 7'b0000100, 4'd15);  // BX lr
  addRow(1, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(1, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(1, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  // ==============================
  // 2 Conditions
  // ==============================
  addRow(2, 32'hE1510002, 1, 0, 0, 1, 4'h0, 7'b0000010, 4'd0);   // CMP
  addRow(2, 32'h00821003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd1);   // ADDEQ, passes
  addRow(2, 32'h10822003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd2);   // ADDNE, fails
  addRow(2, 32'hE1510002, 1, 0, 0, 0, 4'b0100, 7'b0000010, 4'd0); // Z for first CMP
  addRow(2, 32'hA0823003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd3);   // ADDGE, fails
  addRow(2, 32'hB0824003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd4);   // ADDLT, passes
  addRow(2, 32'hE1510002, 1, 0, 0, 0, 4'b1000, 7'b0000010, 4'd0); // N for second CMP
  addRow(2, 32'h80825003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd5);   // ADDHI, passes
  addRow(2, 32'h12556001, 1, 0, 0, 1, 4'h0, 7'b1000010, 4'd6);   // SUBSNE, passes
  addRow(2, 32'h02557001, 1, 0, 0, 0, 4'b0010, 7'b1000010, 4'd7); // SUBSEQ; C for CMP
  addRow(2, 32'hE0828003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd8);   // ADD AL
  addRow(2, 32'h00000000, 0, 0, 0, 0, 4'b1010, 7'b0000000, 4'd0); // From SUBSNE
  addRow(2, 32'h00000000, 0, 0, 0, 0, 4'b0101, 7'b0000000, 4'd0); // SUBSEQ, dropped
  addRow(2, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  // ==============================
  // 3 Latency, back to back
  // ==============================
  addRow(3, 32'hE0829003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd9);
  addRow(3, 32'hE082A003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd10);
  addRow(3, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(3, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(3, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  // ==============================
  // 4 Stall, then flush
  // ==============================
  addRow(4, 32'hE0911002, 1, 0, 0, 1, 4'h0, 7'b1000010, 4'd1);   // ADDS r1
  addRow(4, 32'hE0822003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd2);
  addRow(4, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);   // ADDS moves to commit
  addRow(4, 32'hE0823003, 1, 1, 0, 0, 4'b0101, 7'b1000000, 4'd3); // Held by stall
  addRow(4, 32'hE0823003, 1, 1, 0, 0, 4'b0101, 7'b1000000, 4'd3); // Flags must not load
  addRow(4, 32'hE0823003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd3);   // Accepted here
  addRow(4, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(4, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(4, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(4, 32'hEA000010, 1, 0, 0, 1, 4'h0, 7'b0000100, 4'd15);  // B in flight
  addRow(4, 32'hE0824003, 1, 0, 0, 1, 4'h0, 7'b1000000, 4'd4);
  addRow(4, 32'hE5976004, 1, 0, 1, 1, 4'h0, 7'b1010000, 4'd6);   // Flush drops all
  addRow(4, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(4, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(4, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  // ==============================
  // 5 Undefined and pending PC writes
  // ==============================
  addRow(5, 32'hE0000291, 1, 0, 0, 1, 4'h0, 7'b0000001, 4'd0);   // MUL space
  addRow(5, 32'hEE000000, 1, 0, 0, 1, 4'h0, 7'b0000001, 4'd0);   // Coprocessor
  addRow(5, 32'h0A000004, 1, 0, 0, 1, 4'h0, 7'b0000100, 4'd15);  // BEQ
  addRow(5, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(5, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(5, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
  addRow(5, 32'h00000000, 0, 0, 0, 1, 4'h0, 7'b0000000, 4'd0);
endtask

`endif

//--- verif/armControlTb.sv
`timescale 1ns/1ns
`include "armCtrl_cfg.svh"

module armControlTb;

  localparam int numStages = `ARM_NUM_STAGES;

  logic        clk, reset, instrValid, stall, flush;
  logic [31:0] instr;
  logic [3:0]  aluFlags, flags, rd;
  logic        regWrite, memWrite, memToReg, byteAccess, pcWrite;
  logic        undefInstr, commitValid, pcWritePending;

  // Table columns
  int          tTest[$];
  logic [31:0] tInstr[$];
  logic        tValid[$], tStall[$], tFlush[$], tDc[$];
  logic [3:0]  tFlags[$], tRd[$];
  logic [6:0]  tExp[$];
  bit          tableLoaded;

  // Reference model state
  logic       qValid [numStages];
  int         qIdx [numStages];
  logic [3:0] mFlags;

  int         seed = 87005;
  int         curTest, row, totalChecks, totalErrors;
  int         checkCount [6];
  int         errCount [6];
  logic [3:0] drivenFlags;

  armControlTop dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic addRow(input int test, input logic [31:0] word, input logic valid,
                        input logic stl, input logic fl, input logic dc,
                        input logic [3:0] fIn, input logic [6:0] exp, input logic [3:0] dst);
    tTest.push_back(test);
    tInstr.push_back(word);
    tValid.push_back(valid);
    tStall.push_back(stl);
    tFlush.push_back(fl);
    tDc.push_back(dc);
    tFlags.push_back(fIn);
    tExp.push_back(exp);
    tRd.push_back(dst);
  endtask

  `include "armControlVectors.svh"

  // ARM condition rules, NZCV = f[3:0]
  function automatic logic condPasses(input logic [3:0] cond, input logic [3:0] f);
    case (cond)
      4'h0: return f[2];
      4'h1: return !f[2];
      4'h2: return f[1];
      4'h3: return !f[1];
      4'h4: return f[3];
      4'h5: return !f[3];
      4'h6: return f[0];
      4'h7: return !f[0];
      4'h8: return f[1] && !f[2];
      4'h9: return !f[1] || f[2];
      4'hA: return f[3] == f[0];
      4'hB: return f[3] != f[0];
      4'hC: return !f[2] && (f[3] == f[0]);
      4'hD: return f[2] || (f[3] != f[0]);
      4'hE: return 1'b1;
      default: return 1'b0;  // NV
    endcase
  endfunction

  function automatic string testName(input int t);
    case (t)
      1: return "decode";
      2: return "conditions";
      3: return "latency";
      4: return "stall and flush";
      default: return "reset, undefined and pending";
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount[curTest]++;
    assert (actual === expected) else begin
      $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errCount[curTest]++;
    end
  endtask

  // ==============================
  // Reference model
  // ==============================
  task automatic checkOutputs();
    logic       last, pass, pend;
    int         idx, i;
    logic [6:0] e;
    last = qValid[numStages-1];
    idx  = qIdx[numStages-1];
    e    = last ? tExp[idx] : 7'b0;
    pass = last ? condPasses(tInstr[idx][31:28], mFlags) : 1'b0;
    pend = 1'b0;
    for (i = 0; i < numStages; i++) begin
      pend = pend | (qValid[i] & tExp[qIdx[i]][2]);  // PC writer in flight
    end
    checkValue("commitValid", commitValid, last);
    checkValue("regWrite", regWrite, pass & e[6]);
    checkValue("memWrite", memWrite, pass & e[5]);
    checkValue("pcWrite", pcWrite, pass & e[2]);
    checkValue("undefInstr", undefInstr, pass & e[0]);
    checkValue("flags", flags, mFlags);
    checkValue("pcWritePending", pcWritePending, pend);
    if (last) begin  // Ungated fields
      checkValue("memToReg", memToReg, e[4]);
      checkValue("byteAccess", byteAccess, e[3]);
      checkValue("rd", rd, tRd[idx]);
    end
  endtask

  // One clock edge with the row's inputs
  task automatic stepModel(input int r, input logic [3:0] fIn);
    int idx, i;
    if (!tStall[r]) begin
      idx = qIdx[numStages-1];
      if (qValid[numStages-1] && condPasses(tInstr[idx][31:28], mFlags) && tExp[idx][1])
        mFlags = fIn;
      for (i = numStages - 1; i > 0; i--) begin
        qValid[i] = qValid[i-1] & ~tFlush[r];
        qIdx[i]   = qIdx[i-1];
      end
      qValid[0] = tValid[r] & ~tFlush[r];
      qIdx[0]   = r;
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    reset      = 1'b1;
    instr      = '0;
    instrValid = 1'b0;
    stall      = 1'b0;
    flush      = 1'b0;
    aluFlags   = '0;
    mFlags     = '0;
    for (int i = 0; i < numStages; i++) begin
      qValid[i] = 1'b0;
      qIdx[i]   = 0;
    end
    loadVectors();
    tableLoaded = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    curTest = 5;
    checkOutputs();  // Everything low out of reset
    for (row = 0; row < tInstr.size(); row++) begin
      curTest     = tTest[row];
      drivenFlags = tDc[row] ? 4'($random(seed)) : tFlags[row];
      @(posedge clk);
      instr      <= tInstr[row];
      instrValid <= tValid[row];
      stall      <= tStall[row];
      flush      <= tFlush[row];
      aluFlags   <= drivenFlags;
      @(negedge clk);
      checkOutputs();
      stepModel(row, drivenFlags);
      if (row == tInstr.size() - 1 || tTest[row+1] != tTest[row])
        $display("Test %0d %s: %0d checks, %0d errors", curTest, testName(curTest),
                 checkCount[curTest], errCount[curTest]);
    end
    for (int t = 1; t < 6; t++) begin
      totalChecks += checkCount[t];
      totalErrors += errCount[t];
    end
    $display("Total: %0d checks, %0d errors", totalChecks, totalErrors);
    if (totalErrors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (tableLoaded);
    #((tInstr.size() + numStages + 10) * 20);
    $display("Watchdog expired before the table was applied");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+logic
+incdir+verif
logic/armIsaPkg.sv
logic/armCtrlPkg.sv
logic/instrDecoder.sv
logic/pipeStage.sv
logic/condCommit.sv
logic/armControlTop.sv
verif/armControlTb.sv

//--- Bender.yml
package:
  name: arm_control

sources:
  - include_dirs:
      - logic
    files:
      - logic/armIsaPkg.sv
      - logic/armCtrlPkg.sv
      - logic/instrDecoder.sv
      - logic/pipeStage.sv
      - logic/condCommit.sv
      - logic/armControlTop.sv
  - target: test
    include_dirs:
      - logic
      - verif
    files:
      - verif/armControlTb.sv
